// File: apb_reg_decoder.sv
`timescale 1ns/1ps
`include "regfile_defs.svh"

module apb_reg_decoder (
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [`REGFILE_ADDR_W-1:0]  paddr,
    input  regfile_pkg::reg_word_t      pwdata,

    input  regfile_pkg::reg_word_t      phy_addr_rdata,
    input  regfile_pkg::reg_word_t      phy_mode_rdata,
    input  regfile_pkg::reg_word_t      pkt_ctrl_rdata,
    input  regfile_pkg::reg_word_t      pkt_idle_rdata,
    input  regfile_pkg::reg_word_t      mdio_mem_addr_rdata,
    input  regfile_pkg::reg_word_t      mdio_data_sel_rdata,
    input  regfile_pkg::reg_word_t      mdio_pkt_data_rdata,

    output logic                        pready,
    output regfile_pkg::reg_word_t      prdata,
    output regfile_pkg::reg_wr_stb_t    wr_stb,
    output regfile_pkg::reg_word_t      wdata
);

    import regfile_pkg::*;

    logic       access;
    logic       addr_hit;
    reg_addr_e  offset;

    assign access   = psel & penable;
    assign addr_hit = (paddr[`REGFILE_ADDR_W-1:`REG_OFFSET_W] == '0);
    assign offset   = reg_addr_e'(paddr[`REG_OFFSET_W-1:0]);

    // No wait states
    assign pready = access;
    assign wdata  = pwdata;

    // ------------------------------------------------------------
    // Write strobes
    // ------------------------------------------------------------
    always_comb begin
        wr_stb = '0;
        if (access && pwrite && addr_hit) begin
            case (offset)
                REG_PHY_ADDR:      wr_stb.phy_addr      = 1'b1;
                REG_PHY_MODE:      wr_stb.phy_mode      = 1'b1;
                REG_PKT_CTRL:      wr_stb.pkt_ctrl      = 1'b1;
                REG_PKT_IDLE:      wr_stb.pkt_idle      = 1'b1;
                REG_MDIO_MEM_ADDR: wr_stb.mdio_mem_addr = 1'b1;
                REG_MDIO_DATA_SEL: wr_stb.mdio_data_sel = 1'b1;
                REG_MDIO_PKT_DATA: wr_stb.mdio_pkt_data = 1'b1;
                REG_MDIO_READ:     wr_stb.mdio_read     = 1'b1;
            endcase
        end
    end

    // ------------------------------------------------------------
    // Read data mux
    // ------------------------------------------------------------
    always_comb begin
        prdata = '0;
        if (access && !pwrite && addr_hit) begin
            case (offset)
                REG_PHY_ADDR:      prdata = phy_addr_rdata;
                REG_PHY_MODE:      prdata = phy_mode_rdata;
                REG_PKT_CTRL:      prdata = pkt_ctrl_rdata;
                REG_PKT_IDLE:      prdata = pkt_idle_rdata;
                REG_MDIO_MEM_ADDR: prdata = mdio_mem_addr_rdata;
                REG_MDIO_DATA_SEL: prdata = mdio_data_sel_rdata;
                REG_MDIO_PKT_DATA: prdata = mdio_pkt_data_rdata;
                // Read pulse register is write-only
                default:           prdata = '0;
            endcase
        end
    end

endmodule

// File: build.f
regfile_pkg.sv
apb_reg_decoder.sv
phy_addr_regs.sv
pkt_ctrl_regs.sv
mdio_access_regs.sv
regfile_top.sv
tb_regfile.sv
+incdir+.

// File: mdio_access_regs.sv
`timescale 1ns/1ps
`include "regfile_defs.svh"

module mdio_access_regs (
    input  logic                        clk,
    input  logic                        rst_n,
    input  regfile_pkg::reg_wr_stb_t    wr_stb,
    input  regfile_pkg::reg_word_t      wdata,

    // Device side
    input  logic [`MDIO_PKT_DATA_W-1:0] mdio_pkt_data,
    input  logic                        mdio_pkt_data_we,

    output logic [`MDIO_MEM_ADDR_W-1:0] mdio_memory_addr,
    output logic [`MDIO_DATA_SEL_W-1:0] mdio_data_sel,
    output logic                        mdio_read_pulse,

    output regfile_pkg::reg_word_t      mdio_mem_addr_rdata,
    output regfile_pkg::reg_word_t      mdio_data_sel_rdata,
    output regfile_pkg::reg_word_t      mdio_pkt_data_rdata
);

    import regfile_pkg::*;

    logic [`MDIO_PKT_DATA_W-1:0] pkt_data_q;

    // ------------------------------------------------------------
    // Offsets 0x4 and 0x5, memory address and data select
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mdio_memory_addr <= '0;
        end else if (wr_stb.mdio_mem_addr) begin
            mdio_memory_addr <= wdata[`MDIO_MEM_ADDR_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mdio_data_sel <= '0;
        end else if (wr_stb.mdio_data_sel) begin
            mdio_data_sel <= wdata[`MDIO_DATA_SEL_W-1:0];
        end
    end

    // Captured from the device, bus writes to 0x6 have no effect
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pkt_data_q <= '0;
        end else if (mdio_pkt_data_we) begin
            pkt_data_q <= mdio_pkt_data;
        end
    end

    // Offset 0x7, one clock read request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mdio_read_pulse <= 1'b0;
        end else begin
            mdio_read_pulse <= wr_stb.mdio_read & wdata[0];
        end
    end

    assign mdio_mem_addr_rdata =
        reg_word_t'({{(`REGFILE_DATA_W-`MDIO_MEM_ADDR_W){1'b0}}, mdio_memory_addr});

    assign mdio_data_sel_rdata =
        reg_word_t'({{(`REGFILE_DATA_W-`MDIO_DATA_SEL_W){1'b0}}, mdio_data_sel});

    assign mdio_pkt_data_rdata =
        reg_word_t'({{(`REGFILE_DATA_W-`MDIO_PKT_DATA_W){1'b0}}, pkt_data_q});

endmodule

// File: phy_addr_regs.sv
`timescale 1ns/1ps
`include "regfile_defs.svh"

module phy_addr_regs (
    input  logic                        clk,
    input  logic                        rst_n,
    input  regfile_pkg::reg_wr_stb_t    wr_stb,
    input  regfile_pkg::reg_word_t      wdata,

    output logic [`PHY_ADDR_W-1:0]      legal_phy_addr,
    output logic [`PHY_ADDR_W-1:0]      legal_phy_addr_mask,
    output logic [`PHY_ADDR_W-1:0]      broadcast_addr,
    output logic                        broadcast_mode,
    output logic                        non_zero_detect,
    output logic                        opendrain_mode,
    output logic                        watchdog_enable,
    output logic                        sync_select,

    output regfile_pkg::reg_word_t      phy_addr_rdata,
    output regfile_pkg::reg_word_t      phy_mode_rdata
);

    import regfile_pkg::*;

    // ------------------------------------------------------------
    // Offset 0x0, address fields
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            legal_phy_addr      <= `RST_PHY_ADDR;
            legal_phy_addr_mask <= `RST_PHY_ADDR;
            broadcast_addr      <= `RST_PHY_ADDR;
        end else if (wr_stb.phy_addr) begin
            legal_phy_addr      <= wdata[3*`PHY_ADDR_W-1:2*`PHY_ADDR_W];
            legal_phy_addr_mask <= wdata[2*`PHY_ADDR_W-1:`PHY_ADDR_W];
            broadcast_addr      <= wdata[`PHY_ADDR_W-1:0];
        end
    end

    // ------------------------------------------------------------
    // Offset 0x1, mode bits
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            {broadcast_mode, non_zero_detect, opendrain_mode,
             watchdog_enable, sync_select} <= `RST_MODE_BITS;
        end else if (wr_stb.phy_mode) begin
            broadcast_mode  <= wdata[4];
            non_zero_detect <= wdata[3];
            opendrain_mode  <= wdata[2];
            watchdog_enable <= wdata[1];
            sync_select     <= wdata[0];
        end
    end

    // Bit 15 reserved
    assign phy_addr_rdata = reg_word_t'({1'b0,
                                         legal_phy_addr,
                                         legal_phy_addr_mask,
                                         broadcast_addr});

    assign phy_mode_rdata = reg_word_t'({11'h0,
                                         broadcast_mode,
                                         non_zero_detect,
                                         opendrain_mode,
                                         watchdog_enable,
                                         sync_select});

endmodule

// File: pkt_ctrl_regs.sv
`timescale 1ns/1ps
`include "regfile_defs.svh"

module pkt_ctrl_regs (
    input  logic                        clk,
    input  logic                        rst_n,
    input  regfile_pkg::reg_wr_stb_t    wr_stb,
    input  regfile_pkg::reg_word_t      wdata,

    output logic                        self_test_mode,
    output logic [`PKT_LEN_W-1:0]       pkt_data_length,
    output logic                        capture_mode,
    output logic                        capture_start,
    output logic                        capture_again,
    output logic                        path96_en,
    output regfile_pkg::reg_word_t      pkt_idle_length,

    output regfile_pkg::reg_word_t      pkt_ctrl_rdata,
    output regfile_pkg::reg_word_t      pkt_idle_rdata
);

    import regfile_pkg::*;

    // ------------------------------------------------------------
    // Offset 0x2, packet control
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            self_test_mode  <= 1'b0;
            pkt_data_length <= '0;
            capture_mode    <= 1'b0;
            path96_en       <= `RST_96PATH_EN;
        end else if (wr_stb.pkt_ctrl) begin
            self_test_mode  <= wdata[6];
            pkt_data_length <= wdata[5:4];
            capture_mode    <= wdata[3];
            path96_en       <= wdata[0];
        end
    end

    // Capture pulses, high one clock per write of 1
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            capture_start <= 1'b0;
            capture_again <= 1'b0;
        end else begin
            capture_start <= wr_stb.pkt_ctrl & wdata[2];
            capture_again <= wr_stb.pkt_ctrl & wdata[1];
        end
    end

    // ------------------------------------------------------------
    // Offset 0x3, idle length
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pkt_idle_length <= `RST_IDLE_LENGTH;
        end else if (wr_stb.pkt_idle) begin
            pkt_idle_length <= wdata;
        end
    end

    // Pulse bits read back as zero
    assign pkt_ctrl_rdata = reg_word_t'({9'h0,
                                         self_test_mode,
                                         pkt_data_length,
                                         capture_mode,
                                         2'b00,
                                         path96_en});

    assign pkt_idle_rdata = pkt_idle_length;

endmodule

// File: regfile_defs.svh
`ifndef REGFILE_DEFS_SVH
`define REGFILE_DEFS_SVH

// ------------------------------------------------------------
// Bus widths
// ------------------------------------------------------------
`define REGFILE_ADDR_W      21
`define REGFILE_DATA_W      16

// Low address bits that pick one of the eight registers
`define REG_OFFSET_W        3

// ------------------------------------------------------------
// Field widths
// ------------------------------------------------------------
`define PHY_ADDR_W          5
`define MDIO_MEM_ADDR_W     15
`define MDIO_DATA_SEL_W     7
`define MDIO_PKT_DATA_W     9
`define PKT_LEN_W           2

// ------------------------------------------------------------
// Reset values
// ------------------------------------------------------------
// Legal address, mask and broadcast address
`define RST_PHY_ADDR        5'h1f

`define RST_IDLE_LENGTH     16'h7fff

// Broadcast mode, non-zero detect, open-drain, watchdog, sync select
`define RST_MODE_BITS       5'b10100

`define RST_96PATH_EN       1'b1

`endif

// File: regfile_pkg.sv
`include "regfile_defs.svh"

package regfile_pkg;

    // One register word on the bus
    typedef logic [`REGFILE_DATA_W-1:0] reg_word_t;

    // Register offsets, taken from the low address bits
    typedef enum logic [`REG_OFFSET_W-1:0] {
        REG_PHY_ADDR      = 3'd0,
        REG_PHY_MODE      = 3'd1,
        REG_PKT_CTRL      = 3'd2,
        REG_PKT_IDLE      = 3'd3,
        REG_MDIO_MEM_ADDR = 3'd4,
        REG_MDIO_DATA_SEL = 3'd5,
        REG_MDIO_PKT_DATA = 3'd6,
        REG_MDIO_READ     = 3'd7
    } reg_addr_e;

    // One write strobe per offset
    // Listed from offset 7 down so bit n belongs to offset n
    typedef struct packed {
        logic mdio_read;
        logic mdio_pkt_data;
        logic mdio_data_sel;
        logic mdio_mem_addr;
        logic pkt_idle;
        logic pkt_ctrl;
        logic phy_mode;
        logic phy_addr;
    } reg_wr_stb_t;

endpackage

// File: regfile_top.sv
`timescale 1ns/1ps
`include "regfile_defs.svh"

module regfile_top (
    input  logic                        clk,
    input  logic                        rst_n,

    // APB slave
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [`REGFILE_ADDR_W-1:0]  paddr,
    input  logic [`REGFILE_DATA_W-1:0]  pwdata,
    output logic                        pready,
    output logic [`REGFILE_DATA_W-1:0]  prdata,

    // PHY addressing
    output logic [`PHY_ADDR_W-1:0]      legal_phy_addr,
    output logic [`PHY_ADDR_W-1:0]      legal_phy_addr_mask,
    output logic [`PHY_ADDR_W-1:0]      broadcast_addr,
    output logic                        broadcast_mode,
    output logic                        non_zero_detect,
    output logic                        opendrain_mode,
    output logic                        watchdog_enable,
    output logic                        sync_select,

    // Packet control
    output logic                        self_test_mode,
    output logic [`PKT_LEN_W-1:0]       pkt_data_length,
    output logic                        capture_mode,
    output logic                        capture_start,
    output logic                        capture_again,
    output logic                        path96_en,
    output logic [`REGFILE_DATA_W-1:0]  pkt_idle_length,

    // MDIO memory access
    output logic [`MDIO_MEM_ADDR_W-1:0] mdio_memory_addr,
    output logic [`MDIO_DATA_SEL_W-1:0] mdio_data_sel,
    output logic                        mdio_read_pulse,
    input  logic [`MDIO_PKT_DATA_W-1:0] mdio_pkt_data,
    input  logic                        mdio_pkt_data_we
);

    import regfile_pkg::*;

    reg_wr_stb_t wr_stb;
    reg_word_t   wdata;

    reg_word_t   phy_addr_rdata;
    reg_word_t   phy_mode_rdata;
    reg_word_t   pkt_ctrl_rdata;
    reg_word_t   pkt_idle_rdata;
    reg_word_t   mdio_mem_addr_rdata;
    reg_word_t   mdio_data_sel_rdata;
    reg_word_t   mdio_pkt_data_rdata;

    apb_reg_decoder u_decoder (
        .psel                (psel),
        .penable             (penable),
        .pwrite              (pwrite),
        .paddr               (paddr),
        .pwdata              (pwdata),
        .phy_addr_rdata      (phy_addr_rdata),
        .phy_mode_rdata      (phy_mode_rdata),
        .pkt_ctrl_rdata      (pkt_ctrl_rdata),
        .pkt_idle_rdata      (pkt_idle_rdata),
        .mdio_mem_addr_rdata (mdio_mem_addr_rdata),
        .mdio_data_sel_rdata (mdio_data_sel_rdata),
        .mdio_pkt_data_rdata (mdio_pkt_data_rdata),
        .pready              (pready),
        .prdata              (prdata),
        .wr_stb              (wr_stb),
        .wdata               (wdata)
    );

    phy_addr_regs u_phy_addr_regs (
        .clk                 (clk),
        .rst_n               (rst_n),
        .wr_stb              (wr_stb),
        .wdata               (wdata),
        .legal_phy_addr      (legal_phy_addr),
        .legal_phy_addr_mask (legal_phy_addr_mask),
        .broadcast_addr      (broadcast_addr),
        .broadcast_mode      (broadcast_mode),
        .non_zero_detect     (non_zero_detect),
        .opendrain_mode      (opendrain_mode),
        .watchdog_enable     (watchdog_enable),
        .sync_select         (sync_select),
        .phy_addr_rdata      (phy_addr_rdata),
        .phy_mode_rdata      (phy_mode_rdata)
    );

    pkt_ctrl_regs u_pkt_ctrl_regs (
        .clk                 (clk),
        .rst_n               (rst_n),
        .wr_stb              (wr_stb),
        .wdata               (wdata),
        .self_test_mode      (self_test_mode),
        .pkt_data_length     (pkt_data_length),
        .capture_mode        (capture_mode),
        .capture_start       (capture_start),
        .capture_again       (capture_again),
        .path96_en           (path96_en),
        .pkt_idle_length     (pkt_idle_length),
        .pkt_ctrl_rdata      (pkt_ctrl_rdata),
        .pkt_idle_rdata      (pkt_idle_rdata)
    );

    mdio_access_regs u_mdio_access_regs (
        .clk                 (clk),
        .rst_n               (rst_n),
        .wr_stb              (wr_stb),
        .wdata               (wdata),
        .mdio_pkt_data       (mdio_pkt_data),
        .mdio_pkt_data_we    (mdio_pkt_data_we),
        .mdio_memory_addr    (mdio_memory_addr),
        .mdio_data_sel       (mdio_data_sel),
        .mdio_read_pulse     (mdio_read_pulse),
        .mdio_mem_addr_rdata (mdio_mem_addr_rdata),
        .mdio_data_sel_rdata (mdio_data_sel_rdata),
        .mdio_pkt_data_rdata (mdio_pkt_data_rdata)
    );

endmodule

// File: tb_regfile.sv
`timescale 1ns/1ps
`include "regfile_defs.svh"

module tb_regfile;

    import regfile_pkg::*;

    localparam int MAX_CYCLES = 400;

    logic                        clk;
    logic                        rst_n;
    logic                        psel;
    logic                        penable;
    logic                        pwrite;
    logic [`REGFILE_ADDR_W-1:0]  paddr;
    reg_word_t                   pwdata;
    logic                        pready;
    reg_word_t                   prdata;
    logic [`PHY_ADDR_W-1:0]      legal_phy_addr;
    logic [`PHY_ADDR_W-1:0]      legal_phy_addr_mask;
    logic [`PHY_ADDR_W-1:0]      broadcast_addr;
    logic                        broadcast_mode;
    logic                        non_zero_detect;
    logic                        opendrain_mode;
    logic                        watchdog_enable;
    logic                        sync_select;
    logic                        self_test_mode;
    logic [`PKT_LEN_W-1:0]       pkt_data_length;
    logic                        capture_mode;
    logic                        capture_start;
    logic                        capture_again;
    logic                        path96_en;
    reg_word_t                   pkt_idle_length;
    logic [`MDIO_MEM_ADDR_W-1:0] mdio_memory_addr;
    logic [`MDIO_DATA_SEL_W-1:0] mdio_data_sel;
    logic                        mdio_read_pulse;
    logic [`MDIO_PKT_DATA_W-1:0] mdio_pkt_data;
    logic                        mdio_pkt_data_we;

    int          err_count;
    int          check_count;
    int          test_count;
    int          test_err_start;
    int          cycles;
    logic [31:0] lfsr;

    // Expected read word per offset
    reg_word_t   shadow [0:7];

    regfile_top DUT (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // Checks and stimulus helpers
    // ------------------------------------------------------------
    task automatic check_word(input reg_word_t actual, input reg_word_t expected,
                              input string what);
        check_count++;
        if (actual !== expected) begin
            err_count++;
            $display("Fail at %0d ns: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic check_bit(input logic actual, input logic expected, input string what);
        check_count++;
        if (actual !== expected) begin
            err_count++;
            $display("Fail at %0d ns: %s is %b, expected %b", $time, what, actual, expected);
        end
    endtask

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic reg_word_t rand_bits(input int n);
        reg_word_t v;
        int        i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v = {v[`REGFILE_DATA_W-2:0], lfsr[0]};
        end
        return v;
    endfunction

    // Bits of each offset that hold storage, pulse bits excluded
    function automatic reg_word_t field_mask(input int off);
        case (off)
            0:       return 16'h7fff;
            1:       return 16'h001f;
            2:       return 16'h0079;
            3:       return 16'hffff;
            4:       return 16'h7fff;
            5:       return 16'h007f;
            6:       return 16'h01ff;
            default: return 16'h0000;
        endcase
    endfunction

    task automatic apb_access(input logic wr, input logic [`REGFILE_ADDR_W-1:0] addr,
                              input reg_word_t data, output reg_word_t rdata);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        #1;
        check_bit(pready, 1'b0, "pready in setup phase");
        check_word(prdata, '0, "prdata in setup phase");
        @(negedge clk);
        penable = 1'b1;
        #1;
        check_bit(pready, 1'b1, "pready in access phase");
        rdata = prdata;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        #1;
        check_bit(pready, 1'b0, "pready when idle");
        check_word(prdata, '0, "prdata when idle");
    endtask

    task automatic apb_write(input logic [`REGFILE_ADDR_W-1:0] addr, input reg_word_t data);
        reg_word_t unused;
        apb_access(1'b1, addr, data, unused);
    endtask

    task automatic apb_read(input logic [`REGFILE_ADDR_W-1:0] addr, output reg_word_t data);
        apb_access(1'b0, addr, '0, data);
    endtask

    // Enable without select is not a transfer
    task automatic enable_without_select(input logic [`REGFILE_ADDR_W-1:0] addr,
                                         input reg_word_t data);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b1;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        #1;
        check_bit(pready, 1'b0, "pready with penable but no psel");
        @(negedge clk);
        pwrite = 1'b0;
        #1;
        check_bit(pready, 1'b0, "pready with penable but no psel");
        check_word(prdata, '0, "prdata with penable but no psel");
        @(negedge clk);
        penable = 1'b0;
    endtask

    task automatic read_expect(input logic [`REGFILE_ADDR_W-1:0] addr,
                               input reg_word_t expected);
        reg_word_t data;
        apb_read(addr, data);
        check_word(data, expected, $sformatf("read of address %h", addr));
    endtask

    task automatic compare_fields();
        check_word(reg_word_t'(legal_phy_addr), reg_word_t'(shadow[0][14:10]), "legal_phy_addr");
        check_word(reg_word_t'(legal_phy_addr_mask), reg_word_t'(shadow[0][9:5]),
                   "legal_phy_addr_mask");
        check_word(reg_word_t'(broadcast_addr), reg_word_t'(shadow[0][4:0]), "broadcast_addr");
        check_bit(broadcast_mode, shadow[1][4], "broadcast_mode");
        check_bit(non_zero_detect, shadow[1][3], "non_zero_detect");
        check_bit(opendrain_mode, shadow[1][2], "opendrain_mode");
        check_bit(watchdog_enable, shadow[1][1], "watchdog_enable");
        check_bit(sync_select, shadow[1][0], "sync_select");
        check_bit(self_test_mode, shadow[2][6], "self_test_mode");
        check_word(reg_word_t'(pkt_data_length), reg_word_t'(shadow[2][5:4]), "pkt_data_length");
        check_bit(capture_mode, shadow[2][3], "capture_mode");
        check_bit(path96_en, shadow[2][0], "path96_en");
        check_word(pkt_idle_length, shadow[3], "pkt_idle_length");
        check_word(reg_word_t'(mdio_memory_addr), reg_word_t'(shadow[4][14:0]),
                   "mdio_memory_addr");
        check_word(reg_word_t'(mdio_data_sel), reg_word_t'(shadow[5][6:0]), "mdio_data_sel");
    endtask

    task automatic pulses_low(input string when);
        check_bit(capture_start, 1'b0, {"capture_start ", when});
        check_bit(capture_again, 1'b0, {"capture_again ", when});
        check_bit(mdio_read_pulse, 1'b0, {"mdio_read_pulse ", when});
    endtask

    task automatic report_test(input string name);
        test_count++;
        if (err_count == test_err_start)
            $display("Test %0d %s: ok", test_count, name);
        else
            $display("Test %0d %s: %0d errors", test_count, name, err_count - test_err_start);
        test_err_start = err_count;
    endtask

    // ------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------
    task automatic reset_values();
        int off;
        compare_fields();
        pulses_low("after reset");
        for (off = 0; off < 8; off++)
            read_expect(off, shadow[off]);
        report_test("reset values");
    endtask

    task automatic write_readback();
        reg_word_t data;
        int        off;
        for (off = 0; off < 6; off++) begin
            data = rand_bits(`REGFILE_DATA_W);
            apb_write(off, data);
            shadow[off] = data & field_mask(off);
            read_expect(off, shadow[off]);
        end
        compare_fields();
        report_test("write and read back");
    endtask

    task automatic self_clearing_pulses();
        // Capture start
        shadow[2] = shadow[2] & field_mask(2);
        apb_write(REG_PKT_CTRL, shadow[2] | 16'h0004);
        check_bit(capture_start, 1'b1, "capture_start after write");
        check_bit(capture_again, 1'b0, "capture_again after start write");
        @(negedge clk);
        pulses_low("one clock after write");
        read_expect(REG_PKT_CTRL, shadow[2]);
        // Capture again
        apb_write(REG_PKT_CTRL, shadow[2] | 16'h0002);
        check_bit(capture_again, 1'b1, "capture_again after write");
        check_bit(capture_start, 1'b0, "capture_start after again write");
        @(negedge clk);
        pulses_low("one clock after write");
        read_expect(REG_PKT_CTRL, shadow[2]);
        // MDIO read request
        apb_write(REG_MDIO_READ, 16'h0001);
        check_bit(mdio_read_pulse, 1'b1, "mdio_read_pulse after write");
        @(negedge clk);
        pulses_low("one clock after write");
        read_expect(REG_MDIO_READ, 16'h0000);
        // Zero in the pulse bits
        apb_write(REG_PKT_CTRL, shadow[2]);
        pulses_low("after write of zero");
        apb_write(REG_MDIO_READ, 16'hfffe);
        pulses_low("after write of zero");
        compare_fields();
        report_test("self-clearing pulses");
    endtask

    task automatic packet_capture();
        int rep;
        for (rep = 0; rep < 2; rep++) begin
            @(negedge clk);
            mdio_pkt_data    = `MDIO_PKT_DATA_W'(rand_bits(`MDIO_PKT_DATA_W));
            mdio_pkt_data_we = 1'b1;
            shadow[6]        = reg_word_t'(mdio_pkt_data);
            @(negedge clk);
            mdio_pkt_data_we = 1'b0;
            read_expect(REG_MDIO_PKT_DATA, shadow[6]);
            apb_write(REG_MDIO_PKT_DATA, rand_bits(`REGFILE_DATA_W));
            read_expect(REG_MDIO_PKT_DATA, shadow[6]);
        end
        report_test("captured packet data");
    endtask

    task automatic unmapped_access();
        int off;
        for (off = 8; off < 16; off++) begin
            apb_write(off, rand_bits(`REGFILE_DATA_W));
            pulses_low("after unmapped write");
        end
        // Upper address bits set on mapped offsets
        apb_write(21'h100000 | REG_PHY_ADDR, 16'h0000);
        apb_write(21'h000010 | REG_PKT_CTRL, 16'h0006);
        pulses_low("after unmapped write");
        apb_write(21'h000400 | REG_PKT_IDLE, 16'h1234);
        apb_write(21'h100000 | REG_MDIO_READ, 16'hffff);
        pulses_low("after unmapped write");
        enable_without_select(REG_PKT_IDLE, ~shadow[3]);
        for (off = 8; off < 16; off++)
            read_expect(off, 16'h0000);
        read_expect(21'h100000 | REG_PHY_ADDR, 16'h0000);
        read_expect(21'h000020 | REG_PKT_IDLE, 16'h0000);
        for (off = 0; off < 7; off++)
            read_expect(off, shadow[off]);
        compare_fields();
        report_test("unmapped addresses");
    endtask

    initial begin
        clk              = 1'b0;
        rst_n            = 1'b0;
        psel             = 1'b0;
        penable          = 1'b0;
        pwrite           = 1'b0;
        paddr            = '0;
        pwdata           = '0;
        mdio_pkt_data    = '0;
        mdio_pkt_data_we = 1'b0;
        err_count        = 0;
        check_count      = 0;
        test_count       = 0;
        test_err_start   = 0;
        cycles           = 0;
        lfsr             = 32'h6971_4c19;

        // Reset words from the field layout
        shadow[0] = {1'b0, `RST_PHY_ADDR, `RST_PHY_ADDR, `RST_PHY_ADDR};
        shadow[1] = {11'h0, `RST_MODE_BITS};
        shadow[2] = {15'h0, `RST_96PATH_EN};
        shadow[3] = `RST_IDLE_LENGTH;
        for (int i = 4; i < 8; i++)
            shadow[i] = '0;

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        reset_values();
        write_readback();
        self_clearing_pulses();
        packet_capture();
        unmapped_access();

        $display("Tests: %0d, checks: %0d, errors: %0d", test_count, check_count, err_count);
        if (err_count == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule
